//--- Makefile
SIM = obj_dir/Vtb_atom_io

$(SIM): files.f $(wildcard design/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --top-module tb_atom_io -f files.f

.PHONY: run clean

run: $(SIM)
	out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- design/address_decode.sv
`timescale 1ns/1ps

module address_decode
   (
      input  logic [atom_pkg::addr_w-1:0]     addr,
      input  logic [atom_pkg::rom_bank_w-1:0] rom_bank,
      output logic                            pia_sel,
      output logic                            empty_sel,
      output logic                            latch_sel,
      output logic                            a000_sel,
      output logic                            rom_sel
   );

   // ======================================================================
   // Memory map
   // ======================================================================
   // 0000-9FFF  RAM, video region included
   // A000-AFFF  banked ROM, or RAM when bank is 7
   // B000-B00F  8255 PIA
   // B400-B40F  empty, reads zero
   // BFFF       ROM bank latch
   // C000-FFFF  ROM
   // Everything else in B000-BFFF falls through to RAM

   // Upper nibble of the banked window
   logic [3:0] top_nibble;
   logic       upper_rom;
   logic       bank_on;

   assign top_nibble = addr[15:12];

   // 16 byte device pages
   assign pia_sel   = (addr[15:4] == atom_pkg::pia_page);
   assign empty_sel = (addr[15:4] == atom_pkg::empty_page);

   // Latch is a single byte
   assign latch_sel = (addr == atom_pkg::rom_latch_addr);

   // Banked window
   assign a000_sel = (top_nibble == 4'b1010);

   // C000-FFFF always ROM
   assign upper_rom = (addr[15:14] == 2'b11);

   // Bank 7 turns the A000 window into RAM
   assign bank_on = (rom_bank != atom_pkg::rom_bank_off);

   // Write protect covers every ROM byte
   assign rom_sel = upper_rom | (a000_sel & bank_on);

endmodule

//--- design/atom_io.sv
`timescale 1ns/1ps

module atom_io
   (
      input  logic                            clk64,
      input  logic                            reset,
      input  logic [atom_pkg::addr_w-1:0]     cpu_addr,
      input  logic [atom_pkg::data_w-1:0]     cpu_wdata,
      input  logic                            cpu_we,
      input  logic                            cas_in,
      input  logic                            rept_n,
      input  logic                            fs_n,
      input  logic                            shift_n,
      input  logic                            ctrl_n,
      input  logic [5:0]                      keyout,
      input  logic [2*atom_pkg::data_w-1:0]   ram_rdata,
      output logic                            cpu_clken,
      output logic [atom_pkg::data_w-1:0]     cpu_din,
      output logic [3:0]                      kbd_row,
      output logic                            an_g,
      output logic [2:0]                      gm,
      output logic                            css,
      output logic                            cas_out,
      output logic                            lock,
      output logic [atom_pkg::ram_addr_w-1:0] ram_addr,
      output logic                            ram_we,
      output logic                            ram_oe
   );

   // Slot and tone
   logic cas_tone;

   // Captured bus
   logic [atom_pkg::addr_w-1:0] addr;
   logic [atom_pkg::data_w-1:0] wdata;
   logic                        rnw;

   // Decode results
   logic                            pia_sel;
   logic                            empty_sel;
   logic                            latch_sel;
   logic                            a000_sel;
   logic                            rom_sel;
   logic [atom_pkg::rom_bank_w-1:0] rom_bank;

   // PIA read data
   logic [atom_pkg::data_w-1:0] pia_rdata;

   // ======================================================================
   // Stage 1, timing and capture
   // ======================================================================

   clock_enables u_clock_enables (.clk64(clk64), .reset(reset),
      .cpu_clken(cpu_clken), .cas_tone(cas_tone));

   bus_capture u_bus_capture (.clk64(clk64), .reset(reset), .cpu_clken(cpu_clken),
      .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_we(cpu_we),
      .addr(addr), .wdata(wdata), .rnw(rnw));

   // ======================================================================
   // Stage 2, decode
   // ======================================================================

   address_decode u_address_decode (.addr(addr), .rom_bank(rom_bank),
      .pia_sel(pia_sel), .empty_sel(empty_sel), .latch_sel(latch_sel),
      .a000_sel(a000_sel), .rom_sel(rom_sel));

   // ======================================================================
   // Stage 3, peripherals and read path
   // ======================================================================

   pia_8255 u_pia_8255 (.clk64(clk64), .reset(reset), .cpu_clken(cpu_clken),
      .pia_reg(addr[1:0]), .wdata(wdata), .rnw(rnw), .pia_sel(pia_sel),
      .cas_tone(cas_tone), .cas_in(cas_in), .rept_n(rept_n), .fs_n(fs_n),
      .shift_n(shift_n), .ctrl_n(ctrl_n), .keyout(keyout),
      .pia_rdata(pia_rdata), .kbd_row(kbd_row), .an_g(an_g), .gm(gm),
      .css(css), .cas_out(cas_out));

   memory_map u_memory_map (.clk64(clk64), .reset(reset), .cpu_clken(cpu_clken),
      .addr(addr), .wdata(wdata), .rnw(rnw), .pia_sel(pia_sel),
      .empty_sel(empty_sel), .latch_sel(latch_sel), .a000_sel(a000_sel),
      .rom_sel(rom_sel), .pia_rdata(pia_rdata), .ram_rdata(ram_rdata),
      .rom_bank(rom_bank), .lock(lock), .ram_addr(ram_addr),
      .ram_we(ram_we), .ram_oe(ram_oe), .cpu_din(cpu_din));

endmodule

//--- design/atom_pkg.sv
package atom_pkg;

   // ======================================================================
   // Bus widths
   // ======================================================================

   // 6502 address and data bus
   localparam int addr_w = 16;
   localparam int data_w = 8;

   // External RAM holds 256K bytes
   localparam int ram_addr_w = 18;

   // ======================================================================
   // Clock enables
   // ======================================================================

   // One CPU slot every 64 clk64 cycles
   localparam int slot_div_w = 6;

   // 1 MHz slot rate / 208 / 2 gives the cassette carrier
   localparam int cas_div_count = 208;

   // ======================================================================
   // Memory map
   // ======================================================================

   // Pages compared against addr[15:4]
   localparam logic [11:0] pia_page   = 12'hb00;
   localparam logic [11:0] empty_page = 12'hb40;

   // Single byte locations
   localparam logic [addr_w-1:0] rom_latch_addr = 16'hbfff;
   localparam logic [addr_w-1:0] lock_addr      = 16'h00e7;

   // Lock flag position in the byte at 00E7
   localparam int lock_bit = 5;

   // ROM bank field taken from the latch
   localparam int rom_bank_w = 3;
   localparam logic [rom_bank_w-1:0] rom_bank_off = 3'd7;

   // Top RAM address bits for a banked A000 access
   localparam logic [2:0] bank_ram_prefix = 3'b010;

endpackage

//--- design/bus_capture.sv
`timescale 1ns/1ps

module bus_capture
   (
      input  logic                        clk64,
      input  logic                        reset,
      input  logic                        cpu_clken,
      input  logic [atom_pkg::addr_w-1:0] cpu_addr,
      input  logic [atom_pkg::data_w-1:0] cpu_wdata,
      input  logic                        cpu_we,
      output logic [atom_pkg::addr_w-1:0] addr,
      output logic [atom_pkg::data_w-1:0] wdata,
      output logic                        rnw
   );

   // Core outputs are only valid at the slot edge, so hold them
   // for the whole slot

   // Address and direction, idle as a read of 0000
   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         addr <= '0;
         rnw  <= 1'b1;
      end
      else if (cpu_clken)
      begin
         addr <= cpu_addr;
         rnw  <= ~cpu_we;
      end
   end

   // Write data payload
   always_ff @(posedge clk64)
   begin
      if (cpu_clken)
         wdata <= cpu_wdata;
   end

endmodule

//--- design/clock_enables.sv
`timescale 1ns/1ps

module clock_enables
   (
      input  logic clk64,
      input  logic reset,
      output logic cpu_clken,
      output logic cas_tone
   );

   // ======================================================================
   // CPU slot strobe
   // ======================================================================

   // Free running divider, wraps every 64 cycles
   logic [atom_pkg::slot_div_w-1:0] slot_div;

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         slot_div  <= '0;
         cpu_clken <= 1'b0;
      end
      else
      begin
         slot_div  <= slot_div + 1'b1;
         // Registered, so the pulse lands one cycle after zero
         cpu_clken <= (slot_div == '0);
      end
   end

   // ======================================================================
   // Cassette tone
   // ======================================================================

   // Counts CPU slots, toggles the tone on wrap
   logic [$clog2(atom_pkg::cas_div_count)-1:0] cas_div;

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_div == $bits(cas_div)'(atom_pkg::cas_div_count - 1))
         begin
            cas_div  <= '0;
            cas_tone <= ~cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

endmodule

//--- design/memory_map.sv
`timescale 1ns/1ps

module memory_map
   (
      input  logic                            clk64,
      input  logic                            reset,
      input  logic                            cpu_clken,
      input  logic [atom_pkg::addr_w-1:0]     addr,
      input  logic [atom_pkg::data_w-1:0]     wdata,
      input  logic                            rnw,
      input  logic                            pia_sel,
      input  logic                            empty_sel,
      input  logic                            latch_sel,
      input  logic                            a000_sel,
      input  logic                            rom_sel,
      input  logic [atom_pkg::data_w-1:0]     pia_rdata,
      input  logic [2*atom_pkg::data_w-1:0]   ram_rdata,
      output logic [atom_pkg::rom_bank_w-1:0] rom_bank,
      output logic                            lock,
      output logic [atom_pkg::ram_addr_w-1:0] ram_addr,
      output logic                            ram_we,
      output logic                            ram_oe,
      output logic [atom_pkg::data_w-1:0]     cpu_din
   );

   logic [atom_pkg::data_w-1:0] rom_latch;
   logic                        lock_sel;

   // ======================================================================
   // ROM bank latch and lock snoop
   // ======================================================================

   assign lock_sel = (addr == atom_pkg::lock_addr);

   // Full byte kept so BFFF reads back what was written
   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         rom_latch <= '0;
         lock      <= 1'b0;
      end
      else if (cpu_clken && !rnw)
      begin
         if (latch_sel)
            rom_latch <= wdata;
         // Shadow the OS lock flag as it goes to RAM
         if (lock_sel)
            lock <= wdata[atom_pkg::lock_bit];
      end
   end

   // Only the low bits select a bank
   assign rom_bank = rom_latch[atom_pkg::rom_bank_w-1:0];

   // ======================================================================
   // External RAM
   // ======================================================================

   // A000 window lands in the banked area, all else maps flat
   always_comb
   begin
      if (a000_sel)
         ram_addr = {atom_pkg::bank_ram_prefix, rom_bank, addr[11:0]};
      else
         ram_addr = {{(atom_pkg::ram_addr_w - atom_pkg::addr_w){1'b0}}, addr};
   end

   assign ram_oe = rnw;

   // One cycle write strobe, ROM protected
   assign ram_we = ~rnw & ~rom_sel & cpu_clken;

   // ======================================================================
   // CPU read data
   // ======================================================================

   always_comb
   begin
      if (pia_sel)
         cpu_din = pia_rdata;
      else if (empty_sel)
         cpu_din = '0;
      else if (latch_sel)
         cpu_din = rom_latch;
      // RAM word is 16 bits wide, pick a byte with addr[0]
      else if (addr[0])
         cpu_din = ram_rdata[2*atom_pkg::data_w-1:atom_pkg::data_w];
      else
         cpu_din = ram_rdata[atom_pkg::data_w-1:0];
   end

endmodule

//--- design/pia_8255.sv
`timescale 1ns/1ps

module pia_8255
   (
      input  logic                        clk64,
      input  logic                        reset,
      input  logic                        cpu_clken,
      input  logic [1:0]                  pia_reg,
      input  logic [atom_pkg::data_w-1:0] wdata,
      input  logic                        rnw,
      input  logic                        pia_sel,
      input  logic                        cas_tone,
      input  logic                        cas_in,
      input  logic                        rept_n,
      input  logic                        fs_n,
      input  logic                        shift_n,
      input  logic                        ctrl_n,
      input  logic [5:0]                  keyout,
      output logic [atom_pkg::data_w-1:0] pia_rdata,
      output logic [3:0]                  kbd_row,
      output logic                        an_g,
      output logic [2:0]                  gm,
      output logic                        css,
      output logic                        cas_out
   );

   // Port directions are fixed as the Atom wires them
   // PA out, PB in, PC low out and PC high in

   logic [atom_pkg::data_w-1:0] port_a;
   logic [3:0]                  port_c_lo;
   logic [atom_pkg::data_w-1:0] port_b;
   logic [atom_pkg::data_w-1:0] port_c;
   logic                        pia_write;

   assign pia_write = pia_sel & ~rnw;

   // ======================================================================
   // Register writes
   // ======================================================================

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         port_a    <= '0;
         port_c_lo <= '0;
      end
      else if (cpu_clken && pia_write)
      begin
         case (pia_reg)
            2'b00: port_a <= wdata;
            2'b10: port_c_lo <= wdata[3:0];
            // Control word, bit 7 low means single bit set or reset
            2'b11:
               if (!wdata[7])
                  port_c_lo[wdata[2:1]] <= wdata[0];
            default: ;
         endcase
      end
   end

   // ======================================================================
   // Read side
   // ======================================================================

   // Keyboard columns and modifiers
   assign port_b = {shift_n, ctrl_n, keyout};

   // Sync, repeat and tape bits above the latched nibble
   assign port_c = {fs_n, rept_n, cas_in, cas_tone, port_c_lo};

   always_comb
   begin
      case (pia_reg)
         2'b00:   pia_rdata = port_a;
         2'b01:   pia_rdata = port_b;
         2'b10:   pia_rdata = port_c;
         default: pia_rdata = '0;
      endcase
   end

   // ======================================================================
   // Port outputs
   // ======================================================================

   // Keyboard scan row and VDG mode
   assign kbd_row = port_a[3:0];
   assign an_g    = port_a[4];
   assign gm      = port_a[7:5];
   assign css     = port_c_lo[3];

   // Tape gate, PC0 low forces high, PC1 lets the tone through
   assign cas_out = ~port_c_lo[0] | (port_c_lo[1] & ~cas_tone);

endmodule

//--- files.f
design/atom_pkg.sv
design/clock_enables.sv
design/bus_capture.sv
design/address_decode.sv
design/pia_8255.sv
design/memory_map.sv
design/atom_io.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_atom_io.sv

//--- tb/tb_atom_io.sv
`timescale 1ns/1ps

module tb_atom_io;

   localparam int total_slots = 8 + 40 + 40 + 40 + 450;

   logic        clk64, reset;
   logic [15:0] cpu_addr = '0;
   logic [7:0]  cpu_wdata = '0;
   logic        cpu_we = 1'b0;
   logic        cas_in = 1'b0, rept_n = 1'b1, fs_n = 1'b1, shift_n = 1'b1, ctrl_n = 1'b1;
   logic [5:0]  keyout = '0;
   logic [15:0] ram_rdata = '0;
   logic        cpu_clken, an_g, css, cas_out, lock, ram_we, ram_oe;
   logic [7:0]  cpu_din;
   logic [3:0]  kbd_row;
   logic [2:0]  gm;
   logic [17:0] ram_addr;

   // Expected values and checker strobes
   logic [7:0]  exp_din = '0;
   logic [17:0] exp_ram_addr = '0;
   logic        exp_ram_oe = 1'b1, exp_ram_we = 1'b0, exp_an_g = 1'b0, exp_css = 1'b0;
   logic        exp_cas_out = 1'b1, exp_lock = 1'b0;
   logic [3:0]  exp_kbd_row = '0;
   logic [2:0]  exp_gm = '0;
   logic        chk_main = 1'b0, chk_we = 1'b0, test_done = 1'b0;
   int          test_id = 1;
   int          total_checks, total_errors;

   // Reference model state
   logic [7:0]  m_pa = '0, m_latch = '0, p_data = '0;
   logic [3:0]  m_pc = '0;
   logic        m_lock = 1'b0, p_we = 1'b0;
   logic [15:0] p_addr = '0;
   int          slot_n = 0;
   logic [15:0] lfsr = 16'd14;

   tb_clock u_tb_clock (.clk64(clk64), .reset(reset));

   atom_io u_atom_io (.clk64(clk64), .reset(reset), .cpu_addr(cpu_addr),
      .cpu_wdata(cpu_wdata), .cpu_we(cpu_we), .cas_in(cas_in), .rept_n(rept_n),
      .fs_n(fs_n), .shift_n(shift_n), .ctrl_n(ctrl_n), .keyout(keyout),
      .ram_rdata(ram_rdata), .cpu_clken(cpu_clken), .cpu_din(cpu_din),
      .kbd_row(kbd_row), .an_g(an_g), .gm(gm), .css(css), .cas_out(cas_out),
      .lock(lock), .ram_addr(ram_addr), .ram_we(ram_we), .ram_oe(ram_oe));

   tb_checker u_tb_checker (.clk64(clk64), .reset(reset), .cpu_clken(cpu_clken),
      .chk_main(chk_main), .chk_we(chk_we), .test_done(test_done), .test_id(test_id),
      .cpu_din(cpu_din), .ram_addr(ram_addr), .ram_oe(ram_oe), .ram_we(ram_we),
      .kbd_row(kbd_row), .an_g(an_g), .gm(gm), .css(css), .cas_out(cas_out), .lock(lock),
      .exp_din(exp_din), .exp_ram_addr(exp_ram_addr), .exp_ram_oe(exp_ram_oe),
      .exp_ram_we(exp_ram_we), .exp_kbd_row(exp_kbd_row), .exp_an_g(exp_an_g),
      .exp_gm(exp_gm), .exp_css(exp_css), .exp_cas_out(exp_cas_out), .exp_lock(exp_lock),
      .total_checks(total_checks), .total_errors(total_errors));

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // ======================================================================
   // Reference model
   // ======================================================================

   function automatic logic is_rom(input logic [15:0] a);
      return (a[15:14] == 2'b11) || (a[15:12] == 4'ha && m_latch[2:0] != 3'd7);
   endfunction

   // Retire a captured write
   task automatic apply_write(input logic [15:0] a, input logic [7:0] d, input logic we);
      if (we && a[15:4] == 12'hb00)
      begin
         if (a[1:0] == 2'd0)
            m_pa = d;
         else if (a[1:0] == 2'd2)
            m_pc = d[3:0];
         else if (a[1:0] == 2'd3 && !d[7])
            m_pc[d[2:1]] = d[0];
      end
      if (we && a == 16'hbfff)
         m_latch = d;
      if (we && a == 16'h00e7)
         m_lock = d[5];
   endtask

   task automatic predict(input logic [15:0] a, input logic we);
      logic tone;
      tone = ((slot_n / 208) % 2) == 1;
      exp_ram_oe   = !we;
      exp_ram_addr = (a[15:12] == 4'ha) ? {3'b010, m_latch[2:0], a[11:0]} : {2'b00, a};
      if (a[15:4] == 12'hb00)
         case (a[1:0])
            2'd0:    exp_din = m_pa;
            2'd1:    exp_din = {shift_n, ctrl_n, keyout};
            2'd2:    exp_din = {fs_n, rept_n, cas_in, tone, m_pc};
            default: exp_din = '0;
         endcase
      else if (a[15:4] == 12'hb40)
         exp_din = '0;
      else if (a == 16'hbfff)
         exp_din = m_latch;
      else
         exp_din = a[0] ? ram_rdata[15:8] : ram_rdata[7:0];
      exp_kbd_row = m_pa[3:0];
      exp_an_g    = m_pa[4];
      exp_gm      = m_pa[7:5];
      exp_css     = m_pc[3];
      exp_cas_out = !m_pc[0] || (m_pc[1] && !tone);
      exp_lock    = m_lock;
   endtask

   // ======================================================================
   // Stimulus
   // ======================================================================

   // One bus cycle entered on the falling edge after a capture
   task automatic run_slot(input logic [15:0] a, input logic [7:0] d, input logic we);
      cpu_addr  = a;
      cpu_wdata = d;
      cpu_we    = we;
      @(negedge clk64);
      chk_main = 1'b0;
      while (!cpu_clken)
         @(negedge clk64);
      // Write strobe of the access retiring at this edge
      exp_ram_we = p_we && !is_rom(p_addr);
      chk_we = 1'b1;
      apply_write(p_addr, p_data, p_we);
      slot_n++;
      p_addr = a;
      p_data = d;
      p_we   = we;
      @(negedge clk64);
      chk_we = 1'b0;
      // RAM word and port inputs held for the whole slot of this access
      ram_rdata = 16'(rand_bits(16));
      {cas_in, rept_n, fs_n, shift_n, ctrl_n, keyout} = 11'(rand_bits(11));
      predict(a, we);
      chk_main = 1'b1;
   endtask

   task automatic run_test(input int id, input int n);
      logic [1:0]  sel;
      logic [15:0] a;
      logic [7:0]  d;
      logic        we;
      test_id = id;
      repeat (n)
      begin
         sel = 2'(rand_bits(2));
         d   = 8'(rand_bits(8));
         a   = 16'h0000;
         we  = 1'b0;
         case (id)
            2:
            begin
               a  = {12'hb00, 2'(rand_bits(2)), sel};
               we = (sel != 2'd1) && rand_bits(1) == 1;
            end
            3:
            begin
               a  = (sel == 2'd2) ? {4'ha, 12'(rand_bits(12))} :
                    (sel == 2'd3) ? {2'b11, 14'(rand_bits(14))} : 16'hbfff;
               we = (sel != 2'd1) && (sel != 2'd2 || rand_bits(1) == 1);
            end
            4:
            begin
               a  = (sel == 2'd0) ? 16'(rand_bits(16)) :
                    (sel == 2'd1) ? {12'hb40, 4'(rand_bits(4))} : {1'b0, 15'(rand_bits(15))};
               we = (sel == 2'd2);
            end
            5:
            begin
               a  = (sel == 2'd1) ? 16'hb003 : (sel == 2'd2) ? 16'hb002 : 16'h00e7;
               we = (sel <= 2'd1);
               if (sel == 2'd1)
                  d[7] = 1'b0;
            end
            default: ;
         endcase
         run_slot(a, d, we);
      end
      @(negedge clk64);
      chk_main  = 1'b0;
      test_done = 1'b1;
      @(negedge clk64);
      test_done = 1'b0;
   endtask

   initial
   begin
      wait (!reset);
      run_test(1, 8);
      run_test(2, 40);
      run_test(3, 40);
      run_test(4, 40);
      run_test(5, 450);
      repeat (2) @(negedge clk64);
      $display("Summary: 5 tests, %0d checks, %0d errors", total_checks, total_errors);
      if (total_errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // Watchdog covers all slots plus reset and a margin
   initial
   begin
      #((total_slots + 20) * 64 * 10);
      $display("Watchdog expired before all tests finished");
      $display("Errors found");
      $finish;
   end

endmodule

//--- tb/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
   (
      input  logic        clk64,
      input  logic        reset,
      input  logic        cpu_clken,
      input  logic        chk_main,
      input  logic        chk_we,
      input  logic        test_done,
      input  int          test_id,
      input  logic [7:0]  cpu_din,
      input  logic [17:0] ram_addr,
      input  logic        ram_oe,
      input  logic        ram_we,
      input  logic [3:0]  kbd_row,
      input  logic        an_g,
      input  logic [2:0]  gm,
      input  logic        css,
      input  logic        cas_out,
      input  logic        lock,
      input  logic [7:0]  exp_din,
      input  logic [17:0] exp_ram_addr,
      input  logic        exp_ram_oe,
      input  logic        exp_ram_we,
      input  logic [3:0]  exp_kbd_row,
      input  logic        exp_an_g,
      input  logic [2:0]  exp_gm,
      input  logic        exp_css,
      input  logic        exp_cas_out,
      input  logic        exp_lock,
      output int          total_checks,
      output int          total_errors
   );

   int test_checks = 0;
   int test_errors = 0;
   int gap         = 0;
   logic seen      = 1'b0;
   logic released  = 1'b0;

   initial
   begin
      total_checks = 0;
      total_errors = 0;
   end

   function automatic string test_name(input int id);
      case (id)
         1:       return "slot strobe";
         2:       return "PIA registers";
         3:       return "ROM latch and mapping";
         4:       return "RAM read path";
         default: return "lock and cassette";
      endcase
   endfunction

   task automatic count_error();
      test_errors++;
      total_errors++;
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      test_checks++;
      total_checks++;
      if (got !== exp)
      begin
         $display("** Error %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
         count_error();
      end
   endtask

   // ======================================================================
   // Reset state and slot spacing
   // ======================================================================

   // First edge after release still shows the reset values
   always @(posedge clk64)
   begin
      if (!reset && !released)
      begin
         released = 1'b1;
         check_val("cpu_clken", 32'(cpu_clken), 32'd0);
         check_val("ram_we", 32'(ram_we), 32'd0);
         check_val("lock", 32'(lock), 32'd0);
      end
   end

   // Pulse to pulse distance in clk64 cycles
   always @(posedge clk64)
   begin
      if (!reset)
      begin
         if (cpu_clken)
         begin
            if (seen && gap != 64)
            begin
               $display("Slot strobe came %0d cycles after the previous one", gap);
               count_error();
            end
            seen = 1'b1;
            gap  = 1;
         end
         else
            gap++;
      end
   end

   // ======================================================================
   // Output compare
   // ======================================================================

   always @(posedge clk64)
   begin
      if (chk_we)
         check_val("ram_we", 32'(ram_we), 32'(exp_ram_we));
      if (chk_main)
      begin
         check_val("cpu_din", 32'(cpu_din), 32'(exp_din));
         check_val("ram_addr", 32'(ram_addr), 32'(exp_ram_addr));
         check_val("ram_oe", 32'(ram_oe), 32'(exp_ram_oe));
         check_val("kbd_row", 32'(kbd_row), 32'(exp_kbd_row));
         check_val("an_g", 32'(an_g), 32'(exp_an_g));
         check_val("gm", 32'(gm), 32'(exp_gm));
         check_val("css", 32'(css), 32'(exp_css));
         check_val("cas_out", 32'(cas_out), 32'(exp_cas_out));
         check_val("lock", 32'(lock), 32'(exp_lock));
      end
      if (test_done)
      begin
         $display("Test %0d %s: %0d checks, %0d errors, %s", test_id, test_name(test_id),
                  test_checks, test_errors, (test_errors == 0) ? "pass" : "FAIL");
         test_checks = 0;
         test_errors = 0;
      end
   end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
   (
      output logic clk64,
      output logic reset
   );

   // 10 ns period
   initial
   begin
      clk64 = 1'b0;
      forever #5 clk64 = ~clk64;
   end

   // Held for 10 cycles, released on a falling edge
   initial
   begin
      reset = 1'b1;
      repeat (10) @(negedge clk64);
      reset = 1'b0;
   end

endmodule
